//--- filelist.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_latch.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_stage_top.sv
testbench/tb_decode_stage_assert.sv
testbench/tb_decode_stage.sv

//--- logic/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic              stage_valid,
    input  logic              ready_go,
    input  isa_pkg::ctrl_t    ctrl,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    rs_value,
    input  isa_pkg::word_t    rt_value,
    output pipe_pkg::branch_t branch
);
    import isa_pkg::*;

    word_t seq_pc;
    word_t br_offset;
    logic  cond;

    // targets are relative to the delay slot
    assign seq_pc    = pc + 32'd4;
    assign br_offset = {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};

    always_comb begin
        case (ctrl.branch_kind)
            BR_BEQ:      cond = (rs_value == rt_value);
            BR_BNE:      cond = (rs_value != rt_value);
            BR_J, BR_JR: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.branch_kind)
            BR_J:    branch.target = {seq_pc[31:28], ctrl.jidx, 2'b00};
            BR_JR:   branch.target = rs_value;
            default: branch.target = seq_pc + br_offset;
        endcase
    end

    // only redirect once operands are final
    assign branch.taken = stage_valid && ready_go && cond;

endmodule

//--- logic/decode_latch.sv
`timescale 1ns/1ns

module decode_latch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       fetch_valid,
    input  pipe_pkg::fetch_to_decode_t fetch_bus,
    input  logic                       ready_go,
    input  logic                       exec_allowin,
    output logic                       decode_allowin,
    output logic                       stage_valid,
    output logic                       exec_valid,
    output pipe_pkg::fetch_to_decode_t held
);

    assign decode_allowin = !stage_valid || (ready_go && exec_allowin);
    assign exec_valid     = stage_valid && ready_go;

    // flush wins over a same-cycle accept
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (decode_allowin) begin
            stage_valid <= fetch_valid;
        end
    end

    // payload only moves on an accept
    always_ff @(posedge clk) begin
        if (fetch_valid && decode_allowin) begin
            held <= fetch_bus;
        end
    end

endmodule

//--- logic/decode_stage_top.sv
`timescale 1ns/1ns

module decode_stage_top #(
    parameter int NUM_BYPASS = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_valid,
    input  pipe_pkg::fetch_to_decode_t fetch_bus,
    output logic                      decode_allowin,
    input  logic                      exec_allowin,
    output logic                      exec_valid,
    output pipe_pkg::decode_to_exec_t exec_bus,
    output pipe_pkg::branch_t         branch,
    input  pipe_pkg::rf_write_t       rf_write,
    input  pipe_pkg::bypass_src_t     bypass [NUM_BYPASS],
    input  logic                      flush
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_to_decode_t held;
    logic             stage_valid;
    logic             ready_go;
    ctrl_t            ctrl;
    reg_addr_t        rs;
    reg_addr_t        rt;
    word_t            rf_rs;
    word_t            rf_rt;
    word_t            rs_value;
    word_t            rt_value;

    assign rs = held.inst[25:21];
    assign rt = held.inst[20:16];

    decode_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fetch_valid    (fetch_valid),
        .fetch_bus      (fetch_bus),
        .ready_go       (ready_go),
        .exec_allowin   (exec_allowin),
        .decode_allowin (decode_allowin),
        .stage_valid    (stage_valid),
        .exec_valid     (exec_valid),
        .held           (held)
    );

    inst_decoder u_decoder (
        .inst (held.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (rf_write)
    );

    operand_bypass #(
        .NUM_BYPASS (NUM_BYPASS)
    ) u_bypass (
        .rs       (rs),
        .rt       (rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .bypass   (bypass),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ready_go)
    );

    branch_unit u_branch (
        .stage_valid (stage_valid),
        .ready_go    (ready_go),
        .ctrl        (ctrl),
        .pc          (held.pc),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .branch      (branch)
    );

    assign exec_bus.ctrl     = ctrl;
    assign exec_bus.rs_value = rs_value;
    assign exec_bus.rt_value = rt_value;
    assign exec_bus.pc       = held.pc;

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  isa_pkg::word_t inst,
    output isa_pkg::ctrl_t ctrl
);
    import isa_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       dst_is_r31;
    logic       dst_is_rt;

    assign op    = inst[31:26];
    assign funct = inst[5:0];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];

    always_comb begin
        ctrl             = '0;
        ctrl.alu_op      = ALU_ADD;
        ctrl.src1_sel    = SRC1_REG;
        ctrl.src2_sel    = SRC2_REG;
        ctrl.branch_kind = BR_NONE;
        ctrl.imm         = inst[15:0];
        ctrl.jidx        = inst[25:0];
        dst_is_r31       = 1'b0;
        dst_is_rt        = 1'b0;

        case (op)
            OP_SPECIAL: begin
                ctrl.gr_we = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl.src1_sel = SRC1_SA;
                        ctrl.alu_op   = (funct == FN_SLL) ? ALU_SLL :
                                        (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR: begin
                        ctrl.gr_we       = 1'b0;
                        ctrl.branch_kind = BR_JR;
                    end
                    // unknown funct is a no-op
                    default: ctrl.gr_we = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                ctrl.gr_we    = 1'b1;
                ctrl.src2_sel = SRC2_SIMM;
                dst_is_rt     = 1'b1;
                ctrl.alu_op   = (op == OP_SLTI)  ? ALU_SLT  :
                                (op == OP_SLTIU) ? ALU_SLTU :
                                (op == OP_LUI)   ? ALU_LUI  : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.gr_we    = 1'b1;
                ctrl.src2_sel = SRC2_ZIMM;
                dst_is_rt     = 1'b1;
                ctrl.alu_op   = (op == OP_ANDI) ? ALU_AND :
                                (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LW: begin
                ctrl.gr_we    = 1'b1;
                ctrl.is_load  = 1'b1;
                ctrl.src2_sel = SRC2_SIMM;
                dst_is_rt     = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_we   = 1'b1;
                ctrl.src2_sel = SRC2_SIMM;
            end
            OP_BEQ: ctrl.branch_kind = BR_BEQ;
            OP_BNE: ctrl.branch_kind = BR_BNE;
            OP_J:   ctrl.branch_kind = BR_J;
            OP_JAL: begin
                // link value pc + 8 computed by execute
                ctrl.branch_kind = BR_J;
                ctrl.gr_we       = 1'b1;
                ctrl.src1_sel    = SRC1_PC;
                ctrl.src2_sel    = SRC2_8;
                dst_is_r31       = 1'b1;
            end
            default: ;
        endcase

        ctrl.dest = dst_is_r31 ? 5'd31 :
                    dst_is_rt  ? rt    : rd;
    end

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field, only meaningful under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_REG, SRC1_SA, SRC1_PC} src1_sel_e;
    typedef enum logic [1:0] {SRC2_REG, SRC2_SIMM, SRC2_ZIMM, SRC2_8} src2_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JR} branch_kind_e;

    typedef struct packed {
        alu_op_e      alu_op;
        src1_sel_e    src1_sel;
        src2_sel_e    src2_sel;
        branch_kind_e branch_kind;
        logic         is_load;
        logic         mem_we;
        logic         gr_we;
        reg_addr_t    dest;
        logic [15:0]  imm;
        logic [25:0]  jidx;
    } ctrl_t;

endpackage

//--- logic/operand_bypass.sv
`timescale 1ns/1ns

module operand_bypass #(
    parameter int NUM_BYPASS = 3
) (
    input  isa_pkg::reg_addr_t    rs,
    input  isa_pkg::reg_addr_t    rt,
    input  isa_pkg::word_t        rf_rs,
    input  isa_pkg::word_t        rf_rt,
    input  pipe_pkg::bypass_src_t bypass [NUM_BYPASS],
    output isa_pkg::word_t        rs_value,
    output isa_pkg::word_t        rt_value,
    output logic                  ready_go
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t addr   [2];
    word_t     rf_val [2];
    word_t     value  [2];
    logic      stall  [2];

    function automatic logic hit(bypass_src_t src, reg_addr_t a);
        return src.valid && src.we && (src.dest == a) && (a != '0);
    endfunction

    assign addr[0]   = rs;
    assign addr[1]   = rt;
    assign rf_val[0] = rf_rs;
    assign rf_val[1] = rf_rt;

    // walk from the oldest stage down so index 0 (execute) wins
    always_comb begin
        for (int o = 0; o < 2; o++) begin
            value[o] = rf_val[o];
            stall[o] = 1'b0;
            for (int i = NUM_BYPASS - 1; i >= 0; i--) begin
                if (hit(bypass[i], addr[o])) begin
                    value[o] = bypass[i].data;
                    stall[o] = !bypass[i].data_ready;
                end
            end
        end
    end

    assign rs_value = value[0];
    assign rt_value = value[1];
    assign ready_go = !(stall[0] || stall[1]);

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // fetch -> decode
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_to_decode_t;

    // decode -> execute
    typedef struct packed {
        isa_pkg::ctrl_t ctrl;
        isa_pkg::word_t rs_value;
        isa_pkg::word_t rt_value;
        isa_pkg::word_t pc;
    } decode_to_exec_t;

    // result visibility of one later stage
    typedef struct packed {
        logic              valid;
        logic              we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t    data;
        // low while the value is still being produced, e.g. a load in execute
        logic              data_ready;
    } bypass_src_t;

    // writeback -> register file
    typedef struct packed {
        logic              we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t    wdata;
    } rf_write_t;

    // redirect back to fetch
    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } branch_t;

endpackage

//--- logic/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2,
    input  pipe_pkg::rf_write_t wr
);
    import isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no write-through, same-cycle read sees the old value
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_decode_stage \
    -f filelist.f -o sim_tb

# the simulator may exit non-zero on failure, the log decides
obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log

//--- testbench/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic             clk;
    logic             reset;
    logic             fetch_valid;
    fetch_to_decode_t fetch_bus;
    logic             decode_allowin;
    logic             exec_allowin;
    logic             exec_valid;
    decode_to_exec_t  exec_bus;
    branch_t          branch;
    rf_write_t        rf_write;
    bypass_src_t      bypass [3];
    logic             flush;

    word_t            ref_regs [32];
    fetch_to_decode_t held_m;
    logic             valid_m;
    logic             rdy;
    word_t            exp_rs;
    word_t            exp_rt;
    ctrl_t            exp_ctrl;
    word_t            exp_tgt;
    word_t            pc_ctr;
    int               leaves;

    logic [5:0] r_functs [12] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25,
                                  6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h08};
    logic [5:0] i_ops [13] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                               6'h23, 6'h2b, 6'h04, 6'h05, 6'h02, 6'h03};

    decode_stage_top #(.NUM_BYPASS(3)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic alu_op_e ref_alu(logic [5:0] op, logic [5:0] fn);
        if (op == 6'h00) begin
            case (fn)
                6'h23:   return ALU_SUB;
                6'h2a:   return ALU_SLT;
                6'h2b:   return ALU_SLTU;
                6'h24:   return ALU_AND;
                6'h25:   return ALU_OR;
                6'h26:   return ALU_XOR;
                6'h27:   return ALU_NOR;
                6'h00:   return ALU_SLL;
                6'h02:   return ALU_SRL;
                6'h03:   return ALU_SRA;
                default: return ALU_ADD;
            endcase
        end
        case (op)
            6'h0a:   return ALU_SLT;
            6'h0b:   return ALU_SLTU;
            6'h0c:   return ALU_AND;
            6'h0d:   return ALU_OR;
            6'h0e:   return ALU_XOR;
            6'h0f:   return ALU_LUI;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic ctrl_t ref_ctrl(word_t inst);
        ctrl_t      c;
        logic [5:0] op;
        logic [5:0] fn;
        logic       r_alu;
        logic       imm_alu;
        op = inst[31:26];
        fn = inst[5:0];
        r_alu = (op == 6'h00) && (fn inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                             6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03});
        imm_alu = op inside {6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23};
        c = '0;
        c.alu_op = ref_alu(op, fn);
        c.imm = inst[15:0];
        c.jidx = inst[25:0];
        c.gr_we = r_alu || imm_alu || (op == 6'h03);
        c.is_load = (op == 6'h23);
        c.mem_we = (op == 6'h2b);
        c.src1_sel = (op == 6'h00 && fn inside {6'h00, 6'h02, 6'h03}) ? SRC1_SA :
                     (op == 6'h03) ? SRC1_PC : SRC1_REG;
        c.src2_sel = (op == 6'h03) ? SRC2_8 :
                     (op inside {6'h0c, 6'h0d, 6'h0e}) ? SRC2_ZIMM :
                     (imm_alu || op == 6'h2b) ? SRC2_SIMM : SRC2_REG;
        c.branch_kind = (op == 6'h04) ? BR_BEQ :
                        (op == 6'h05) ? BR_BNE :
                        (op == 6'h02 || op == 6'h03) ? BR_J :
                        (op == 6'h00 && fn == 6'h08) ? BR_JR : BR_NONE;
        c.dest = (op == 6'h03) ? 5'd31 : imm_alu ? inst[20:16] : inst[15:11];
        return c;
    endfunction

    // lowest bypass index wins over the register file
    function automatic word_t operand(reg_addr_t a);
        for (int i = 0; i < 3; i++) begin
            if (bypass[i].valid && bypass[i].we && bypass[i].dest == a && a != 0)
                return bypass[i].data;
        end
        return (a == 0) ? 32'd0 : ref_regs[a];
    endfunction

    function automatic logic operand_ready(reg_addr_t a);
        for (int i = 0; i < 3; i++) begin
            if (bypass[i].valid && bypass[i].we && bypass[i].dest == a && a != 0)
                return bypass[i].data_ready;
        end
        return 1'b1;
    endfunction

    function automatic logic ref_taken(word_t inst, word_t rsv, word_t rtv);
        logic [5:0] op;
        op = inst[31:26];
        if (op == 6'h04)
            return rsv == rtv;
        if (op == 6'h05)
            return rsv != rtv;
        return (op == 6'h02) || (op == 6'h03) || (op == 6'h00 && inst[5:0] == 6'h08);
    endfunction

    function automatic word_t ref_target(fetch_to_decode_t w, word_t rsv);
        word_t seq;
        seq = w.pc + 32'd4;
        if (w.inst[31:26] == 6'h02 || w.inst[31:26] == 6'h03)
            return {seq[31:28], w.inst[25:0], 2'b00};
        if (w.inst[31:26] == 6'h00)
            return rsv;
        return seq + {{14{w.inst[15]}}, w.inst[15:0], 2'b00};
    endfunction

    function automatic word_t rand_inst();
        word_t w;
        int    k;
        w = $urandom;
        w[25:21] = 5'($urandom_range(7, 0));
        w[20:16] = 5'($urandom_range(7, 0));
        w[15:11] = 5'($urandom_range(7, 0));
        k = $urandom_range(24, 0);
        if (k < 12) begin
            w[31:26] = 6'h00;
            w[5:0] = r_functs[k];
        end else begin
            w[31:26] = i_ops[k-12];
        end
        return w;
    endfunction

    // negedge sees the values the next rising edge will act on
    always @(negedge clk) begin
        if (reset) begin
            valid_m = 1'b0;
        end else begin
            rdy = operand_ready(held_m.inst[25:21]) && operand_ready(held_m.inst[20:16]);
            check(exec_valid == (valid_m && rdy), "exec_valid differs from expected");
            check(decode_allowin == (!valid_m || (rdy && exec_allowin)),
                  "decode_allowin differs from expected");
            if (!(valid_m && rdy))
                check(!branch.taken, "branch taken with no valid word");
            if (valid_m && rdy && exec_allowin) begin
                exp_rs = operand(held_m.inst[25:21]);
                exp_rt = operand(held_m.inst[20:16]);
                exp_ctrl = ref_ctrl(held_m.inst);
                check(exec_bus.ctrl == exp_ctrl,
                      $sformatf("ctrl mismatch for inst %h", held_m.inst));
                check(exec_bus.rs_value == exp_rs,
                      $sformatf("rs_value %h, expected %h", exec_bus.rs_value, exp_rs));
                check(exec_bus.rt_value == exp_rt,
                      $sformatf("rt_value %h, expected %h", exec_bus.rt_value, exp_rt));
                check(exec_bus.pc == held_m.pc, "pc mismatch");
                check(branch.taken == ref_taken(held_m.inst, exp_rs, exp_rt),
                      $sformatf("branch.taken wrong for inst %h", held_m.inst));
                if (exp_ctrl.branch_kind != BR_NONE) begin
                    exp_tgt = ref_target(held_m, exp_rs);
                    check(branch.target == exp_tgt,
                          $sformatf("branch.target %h, expected %h", branch.target, exp_tgt));
                end
                leaves++;
            end
            if (flush) begin
                valid_m = 1'b0;
            end else if (!valid_m || (rdy && exec_allowin)) begin
                valid_m = fetch_valid;
                if (fetch_valid)
                    held_m = fetch_bus;
            end
            if (rf_write.we && rf_write.waddr != 0)
                ref_regs[rf_write.waddr] = rf_write.wdata;
        end
    end

    task automatic send(input word_t inst, input logic rnd_write);
        int t;
        fetch_bus.pc = pc_ctr;
        fetch_bus.inst = inst;
        fetch_valid = 1'b1;
        pc_ctr = pc_ctr + 32'd4;
        t = 0;
        @(negedge clk);
        while (!decode_allowin) begin
            t++;
            if (t > 50)
                fail_timeout("decode_allowin");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        rf_write.we = rnd_write ? 1'($urandom_range(1, 0)) : 1'b0;
        rf_write.waddr = 5'($urandom_range(7, 0));
        rf_write.wdata = $urandom;
    endtask

    task automatic wait_leave();
        int t;
        t = 0;
        @(negedge clk);
        while (!(exec_valid && exec_allowin)) begin
            t++;
            if (t > 50)
                fail_timeout("a word to leave the stage");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic clear_bypass();
        for (int i = 0; i < 3; i++)
            bypass[i] = '0;
    endtask

    initial begin
        void'($urandom(32'hebc0_f90a));
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_bus = '0;
        exec_allowin = 1'b1;
        rf_write = '0;
        flush = 1'b0;
        clear_bypass();
        ref_regs = '{default: '0};
        pc_ctr = 32'hbfc0_0000;
        leaves = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // every register gets a value including zero
        for (int r = 0; r < 32; r++) begin
            rf_write.we = 1'b1;
            rf_write.waddr = 5'(r);
            rf_write.wdata = $urandom;
            @(posedge clk);
            #1;
        end
        rf_write.we = 1'b0;

        repeat (80) send(rand_inst(), 1'b1);

        repeat (120) begin
            for (int i = 0; i < 3; i++) begin
                bypass[i].valid = 1'($urandom_range(1, 0));
                bypass[i].we = 1'($urandom_range(1, 0));
                bypass[i].dest = 5'($urandom_range(7, 0));
                bypass[i].data = $urandom;
                bypass[i].data_ready = 1'b1;
            end
            send(rand_inst(), 1'b1);
        end

        // stall on r5 from memory until its data shows up
        clear_bypass();
        @(posedge clk);
        #1;
        bypass[1] = '{valid: 1'b1, we: 1'b1, dest: 5'd5, data: 32'h1234_5678,
                      data_ready: 1'b0};
        send({6'h04, 5'd5, 5'd3, 16'h0010}, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        bypass[1].data_ready = 1'b1;
        wait_leave();

        // back-pressure
        clear_bypass();
        @(posedge clk);
        #1;
        exec_allowin = 1'b0;
        send(rand_inst(), 1'b0);
        fetch_bus.pc = pc_ctr;
        fetch_bus.inst = rand_inst();
        fetch_valid = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        exec_allowin = 1'b1;
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;

        // flush the word that just came in
        exec_allowin = 1'b0;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        exec_allowin = 1'b1;
        repeat (3) @(posedge clk);

        if (leaves >= 200) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("only %0d words left the stage", leaves);
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_decode_stage_assert.sv
`timescale 1ns/1ns

module handshake_checks (
    input logic                      clk,
    input logic                      reset,
    input logic                      flush,
    input logic                      exec_valid,
    input logic                      exec_allowin,
    input pipe_pkg::decode_to_exec_t exec_bus,
    input pipe_pkg::branch_t         branch
);

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !exec_valid)
        else $error("exec_valid high in the cycle after flush");

    // held word must not move while execute refuses it
    bus_holds: assert property (@(posedge clk) disable iff (reset)
        (exec_valid && !exec_allowin) |=> $stable(exec_bus))
        else $error("exec_bus changed under back-pressure");

    taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
        branch.taken |-> exec_valid)
        else $error("branch taken without exec_valid");

endmodule

bind decode_stage_top handshake_checks checks_i (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .exec_valid   (exec_valid),
    .exec_allowin (exec_allowin),
    .exec_bus     (exec_bus),
    .branch       (branch)
);
